/* Makefile */
TOP := drp_regs_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): flist.f $(shell cat flist.f)
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

lint:
	verilator --lint-only -Wall --timing --assert -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* common/drp_bus_pkg.sv */
package drp_bus_pkg;

    // width of the DRP data path
    localparam int DATA_W = 16;

    // one DRP word, used for write data, read data and register contents
    typedef logic [DATA_W-1:0] drp_word_t;

endpackage

/* common/drp_regmap_pkg.sv */
package drp_regmap_pkg;

    // registers in the bank, at REG_BASE .. REG_BASE+NUM_REGS-1
    localparam int NUM_REGS = 4;

    // width of a register index
    localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

    typedef logic [IDX_W-1:0] reg_idx_t;

    // one bit per register, for the set and get strobes
    typedef logic [NUM_REGS-1:0] reg_sel_t;

    // loaded into every register on reset
    localparam drp_bus_pkg::drp_word_t REG_RESET = '0;

endpackage

/* common/drp_stage_if.sv */
`timescale 1ns/1ps

interface drp_stage_if;

    // one-hot strobes, all zero for an unmapped address
    drp_regmap_pkg::reg_sel_t  set;
    drp_regmap_pkg::reg_sel_t  get;

    // write word, held from the request until the next one
    drp_bus_pkg::drp_word_t    wdata;

    // acknowledge timing, one cycle each
    logic                      wr_done;
    logic                      rd_done;

    modport dec_mp (
        output set,
        output get,
        output wdata,
        output wr_done,
        output rd_done
    );

    modport exec_mp (
        input  set,
        input  wdata
    );

    modport res_mp (
        input  get,
        input  wr_done,
        input  rd_done
    );

endinterface

/* drp_regs/drp_addr_decode.sv */
`timescale 1ns/1ps

module drp_addr_decode #(
    parameter int DRP_ABITS = 8,
    parameter int REG_BASE  = 8
) (
    input  logic                    drp_clk,
    input  logic                    drp_rst,
    input  logic                    drp_en,
    input  logic                    drp_we,
    input  logic [DRP_ABITS-1:0]    drp_addr,
    input  drp_bus_pkg::drp_word_t  drp_di,
    drp_stage_if.dec_mp             stage
);

    logic                       en_q;
    logic                       we_q;
    logic [DRP_ABITS-1:0]       addr_q;
    drp_bus_pkg::drp_word_t     di_q;
    logic                       wr_q;
    logic [1:0]                 rd_q;
    logic [DRP_ABITS-1:0]       offset;
    drp_regmap_pkg::reg_idx_t   idx;
    logic                       hit;
    drp_regmap_pkg::reg_sel_t   sel;

    // request payload, only taken on drp_en
    always_ff @(posedge drp_clk) begin
        if (drp_en) begin
            addr_q <= drp_addr;
            di_q   <= drp_di;
        end
    end

    // request flags; the read flag runs one stage longer
    always_ff @(posedge drp_clk) begin
        if (drp_rst) begin
            en_q <= 1'b0;
            we_q <= 1'b0;
            wr_q <= 1'b0;
            rd_q <= 2'b00;
        end else begin
            // strobe sampled at the request edge
            en_q <= drp_en;
            we_q <= drp_we;
            wr_q <= en_q & we_q;
            rd_q <= {rd_q[0], en_q & ~we_q};
        end
    end

    // offset into the bank, wraps to a large value below REG_BASE
    always_comb begin
        offset = addr_q - DRP_ABITS'(REG_BASE);
        hit    = offset < DRP_ABITS'(drp_regmap_pkg::NUM_REGS);
        idx    = drp_regmap_pkg::reg_idx_t'(offset);
        sel    = hit ? (drp_regmap_pkg::reg_sel_t'(1) << idx) : '0;
    end

    always_ff @(posedge drp_clk) begin
        if (drp_rst) begin
            stage.set     <= '0;
            stage.get     <= '0;
            stage.wr_done <= 1'b0;
            stage.rd_done <= 1'b0;
        end else begin
            stage.set     <= wr_q ? sel : '0;
            stage.get     <= rd_q[0] ? sel : '0;
            // acknowledged even when nothing was selected
            stage.wr_done <= wr_q;
            stage.rd_done <= rd_q[1];
        end
    end

    assign stage.wdata = di_q;

endmodule

/* drp_regs/drp_read_return.sv */
`timescale 1ns/1ps

module drp_read_return (
    input  logic                    drp_clk,
    input  logic                    drp_rst,
    drp_stage_if.res_mp             stage,
    input  drp_bus_pkg::drp_word_t [drp_regmap_pkg::NUM_REGS-1:0] regs,
    output logic                    drp_rdy,
    output drp_bus_pkg::drp_word_t  drp_do
);

    drp_bus_pkg::drp_word_t     rd_mux;
    drp_bus_pkg::drp_word_t     rd_hold;

    // and-or select, zero when get is empty
    always_comb begin
        rd_mux = '0;
        for (int i = 0; i < drp_regmap_pkg::NUM_REGS; i++) begin
            rd_mux = rd_mux | ({drp_bus_pkg::DATA_W{stage.get[i]}} & regs[i]);
        end
    end

    // sampled one cycle after get, before any write in the same edge lands
    always_ff @(posedge drp_clk) begin
        rd_hold <= rd_mux;
    end

    always_ff @(posedge drp_clk) begin
        if (drp_rst) begin
            drp_rdy <= 1'b0;
            drp_do  <= '0;
        end else begin
            drp_rdy <= stage.wr_done | stage.rd_done;
            // drp_do stays zero outside a read acknowledge
            drp_do  <= stage.rd_done ? rd_hold : '0;
        end
    end

endmodule

/* drp_regs/drp_reg_bank.sv */
`timescale 1ns/1ps

module drp_reg_bank (
    input  logic                    drp_clk,
    input  logic                    drp_rst,
    drp_stage_if.exec_mp            stage,
    output drp_bus_pkg::drp_word_t [drp_regmap_pkg::NUM_REGS-1:0] regs
);

    drp_bus_pkg::drp_word_t [drp_regmap_pkg::NUM_REGS-1:0] bank_q;

    // set is one-hot, so at most one register loads per cycle
    always_ff @(posedge drp_clk) begin
        if (drp_rst) begin
            for (int i = 0; i < drp_regmap_pkg::NUM_REGS; i++) begin
                bank_q[i] <= drp_regmap_pkg::REG_RESET;
            end
        end else begin
            for (int i = 0; i < drp_regmap_pkg::NUM_REGS; i++) begin
                if (stage.set[i]) begin
                    bank_q[i] <= stage.wdata;
                end
            end
        end
    end

    // levels for the read path and for logic outside
    assign regs = bank_q;

endmodule

/* dv/drp_regs_assert.sv */
`timescale 1ns/1ps

module drp_regs_assert #(
    parameter bit CHECK_SET = 1'b1
) (
    input  logic                        drp_clk,
    input  logic                        drp_rst,
    input  logic                        rdy,
    input  drp_regmap_pkg::reg_sel_t    set,
    input  drp_regmap_pkg::reg_sel_t    get
);

    // master waits for each ack, so two acks never touch
    rdy_single: assert property (@(posedge drp_clk) disable iff (drp_rst) rdy |=> !rdy)
        else $error("acknowledge was high on two consecutive cycles");

    get_onehot: assert property (@(posedge drp_clk) disable iff (drp_rst) $onehot0(get))
        else $error("get strobe has more than one bit high");

    generate
        if (CHECK_SET) begin : g_set
            set_onehot: assert property (@(posedge drp_clk) disable iff (drp_rst)
                $onehot0(set))
                else $error("set strobe has more than one bit high");

            // a write and a read never decode in the same cycle
            no_overlap: assert property (@(posedge drp_clk) disable iff (drp_rst)
                (set == '0) || (get == '0))
                else $error("set and get strobes are high at the same time");
        end
    endgenerate

endmodule

bind drp_read_return drp_regs_assert #(
    .CHECK_SET (1'b0)
) u_result_assert (
    .drp_clk (drp_clk),
    .drp_rst (drp_rst),
    .rdy     (drp_rdy),
    .set     ('0),
    .get     (stage.get)
);

bind drp_addr_decode drp_regs_assert #(
    .CHECK_SET (1'b1)
) u_decode_assert (
    .drp_clk (drp_clk),
    .drp_rst (drp_rst),
    .rdy     (stage.wr_done | stage.rd_done),
    .set     (stage.set),
    .get     (stage.get)
);

/* dv/drp_regs_tb.sv */
`timescale 1ns/1ps

module drp_regs_tb;

    localparam int DRP_ABITS   = 8;
    localparam int REG_BASE    = 8;
    localparam int NUM_REGS    = drp_regmap_pkg::NUM_REGS;
    localparam int WR_LATENCY  = 3;
    localparam int RD_LATENCY  = 4;
    localparam int RDY_TIMEOUT = 20;
    localparam int NUM_RANDOM  = 400;

    logic                    drp_clk;
    logic                    drp_rst;
    logic                    drp_en;
    logic                    drp_we;
    logic [DRP_ABITS-1:0]    drp_addr;
    drp_bus_pkg::drp_word_t  drp_di;
    logic                    drp_rdy;
    drp_bus_pkg::drp_word_t  drp_do;
    drp_bus_pkg::drp_word_t [NUM_REGS-1:0] drp_register;

    // mirror of the register bank
    drp_bus_pkg::drp_word_t  model [NUM_REGS];

    int seed          = 32'h74163e02;
    int error_count   = 0;
    int idle_errors   = 0;
    int timeout_count = 0;
    bit timed_out     = 1'b0;

    // offsets around the bank that must not decode
    int unmapped_off [4] = '{-2, -1, 4, 5};

    drp_regs_top #(
        .DRP_ABITS    (DRP_ABITS),
        .REG_BASE     (REG_BASE)
    ) dut (
        .drp_clk      (drp_clk),
        .drp_rst      (drp_rst),
        .drp_en       (drp_en),
        .drp_we       (drp_we),
        .drp_addr     (drp_addr),
        .drp_di       (drp_di),
        .drp_rdy      (drp_rdy),
        .drp_do       (drp_do),
        .drp_register (drp_register)
    );

    initial begin
        drp_clk = 1'b0;
        forever #5 drp_clk = ~drp_clk;
    end

    function automatic bit is_mapped(input logic [DRP_ABITS-1:0] addr);
        return (addr >= DRP_ABITS'(REG_BASE)) && (addr < DRP_ABITS'(REG_BASE + NUM_REGS));
    endfunction

    task automatic check_register();
        for (int i = 0; i < NUM_REGS; i++) begin
            assert (drp_register[i] == model[i]) else begin
                error_count++;
                $display("[ERROR] %0t: drp_register[%0d] is 0x%04h, expected 0x%04h",
                         $time, i, drp_register[i], model[i]);
            end
        end
    endtask

    task automatic do_request(input logic we, input logic [DRP_ABITS-1:0] addr,
                              input drp_bus_pkg::drp_word_t data);
        int                         lat;
        int                         expect_lat;
        bit                         got_rdy;
        bit                         mapped;
        drp_regmap_pkg::reg_idx_t   idx;
        drp_bus_pkg::drp_word_t     expect_do;
        if (timed_out) begin
            return;
        end
        mapped     = is_mapped(addr);
        idx        = drp_regmap_pkg::reg_idx_t'(addr - DRP_ABITS'(REG_BASE));
        expect_lat = we ? WR_LATENCY : RD_LATENCY;
        expect_do  = (!we && mapped) ? model[idx] : '0;

        @(posedge drp_clk);
        drp_en   <= 1'b1;
        drp_we   <= we;
        drp_addr <= addr;
        drp_di   <= data;
        // request edge
        @(posedge drp_clk);
        drp_en   <= 1'b0;
        drp_we   <= 1'b0;

        // lat counts edges after the request edge
        lat     = 0;
        got_rdy = 1'b0;
        while (!got_rdy && lat <= RDY_TIMEOUT) begin
            @(negedge drp_clk);
            if (drp_rdy) begin
                got_rdy = 1'b1;
            end else begin
                lat++;
            end
        end
        if (!got_rdy) begin
            timeout_count++;
            timed_out = 1'b1;
            $display("timeout: drp_rdy never came within %0d cycles of a %s at address 0x%02h",
                     RDY_TIMEOUT, we ? "write" : "read", addr);
            return;
        end

        if (we && mapped) begin
            model[idx] = data;
        end
        assert (lat == expect_lat) else begin
            error_count++;
            $display("[ERROR] %0t: %s at 0x%02h acknowledged after %0d cycles, expected %0d",
                     $time, we ? "write" : "read", addr, lat, expect_lat);
        end
        if (!we) begin
            assert (drp_do == expect_do) else begin
                error_count++;
                $display("[ERROR] %0t: read at 0x%02h returned 0x%04h, expected 0x%04h",
                         $time, addr, drp_do, expect_do);
            end
        end
        check_register();
    endtask

    // drp_do must be quiet outside an acknowledge
    always @(negedge drp_clk) begin
        if (!drp_rst && !drp_rdy) begin
            assert (drp_do == '0) else begin
                idle_errors++;
                $display("[ERROR] %0t: drp_do is 0x%04h while drp_rdy is low", $time, drp_do);
            end
        end
    end

    initial begin
        logic [31:0]            r;
        logic [DRP_ABITS-1:0]   addr;
        drp_bus_pkg::drp_word_t data;

        drp_rst  = 1'b1;
        drp_en   = 1'b0;
        drp_we   = 1'b0;
        drp_addr = '0;
        drp_di   = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model[i] = '0;
        end

        repeat (2) @(posedge drp_clk);
        drp_rst <= 1'b0;
        @(negedge drp_clk);

        // registers come out of reset cleared
        check_register();
        for (int i = 0; i < NUM_REGS; i++) begin
            do_request(1'b0, DRP_ABITS'(REG_BASE + i), '0);
        end

        // one write per register, then read them back
        for (int i = 0; i < NUM_REGS; i++) begin
            data = drp_bus_pkg::drp_word_t'($random(seed));
            do_request(1'b1, DRP_ABITS'(REG_BASE + i), data);
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            do_request(1'b0, DRP_ABITS'(REG_BASE + i), '0);
        end

        // addresses just outside the bank
        for (int k = 0; k < 4; k++) begin
            data = drp_bus_pkg::drp_word_t'($random(seed));
            do_request(1'b1, DRP_ABITS'(REG_BASE + unmapped_off[k]), data);
            do_request(1'b0, DRP_ABITS'(REG_BASE + unmapped_off[k]), '0);
        end

        // mixed traffic over REG_BASE-2 .. REG_BASE+5
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r    = $random(seed);
            addr = DRP_ABITS'(REG_BASE - 2) + DRP_ABITS'(r[3:1]);
            data = drp_bus_pkg::drp_word_t'($random(seed));
            do_request(r[0], addr, data);
        end

        repeat (2) @(posedge drp_clk);
        $display("errors: %0d check failures, %0d drp_do idle failures, %0d timeouts",
                 error_count, idle_errors, timeout_count);
        if (error_count + idle_errors + timeout_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* flist.f */
common/drp_bus_pkg.sv
common/drp_regmap_pkg.sv
common/drp_stage_if.sv
drp_regs/drp_addr_decode.sv
drp_regs/drp_reg_bank.sv
drp_regs/drp_read_return.sv
source/drp_regs_top.sv
dv/drp_regs_assert.sv
dv/drp_regs_tb.sv

/* source/drp_regs_top.sv */
`timescale 1ns/1ps

module drp_regs_top #(
    parameter int DRP_ABITS = 8,
    parameter int REG_BASE  = 8
) (
    input  logic                    drp_clk,
    input  logic                    drp_rst,
    input  logic                    drp_en,
    input  logic                    drp_we,
    input  logic [DRP_ABITS-1:0]    drp_addr,
    input  drp_bus_pkg::drp_word_t  drp_di,
    output logic                    drp_rdy,
    output drp_bus_pkg::drp_word_t  drp_do,
    output drp_bus_pkg::drp_word_t [drp_regmap_pkg::NUM_REGS-1:0] drp_register
);

    drp_bus_pkg::drp_word_t [drp_regmap_pkg::NUM_REGS-1:0] regs;

    drp_stage_if stage_if ();

    // decode: registers the request, builds the strobes
    drp_addr_decode #(
        .DRP_ABITS (DRP_ABITS),
        .REG_BASE  (REG_BASE)
    ) u_decode (
        .drp_clk   (drp_clk),
        .drp_rst   (drp_rst),
        .drp_en    (drp_en),
        .drp_we    (drp_we),
        .drp_addr  (drp_addr),
        .drp_di    (drp_di),
        .stage     (stage_if.dec_mp)
    );

    // execute: the register bank
    drp_reg_bank u_bank (
        .drp_clk   (drp_clk),
        .drp_rst   (drp_rst),
        .stage     (stage_if.exec_mp),
        .regs      (regs)
    );

    // result: read data and drp_rdy
    drp_read_return u_result (
        .drp_clk   (drp_clk),
        .drp_rst   (drp_rst),
        .stage     (stage_if.res_mp),
        .regs      (regs),
        .drp_rdy   (drp_rdy),
        .drp_do    (drp_do)
    );

    assign drp_register = regs;

endmodule
